//--- design/sdram_access_seq.sv
// bus owner that passes init commands through, then runs one access at a time
// accesses use auto precharge so no row stays open and the burst length is 1
// req and its fields must stay steady until ack and T_RCD, T_RP, T_RFC must be 2 or more
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_access_seq
	import sdram_cmd_pkg::*;
	import sdram_host_pkg::*;
(
	input  logic                          sd_clk,
	input  logic                          reset,
	input  sdram_cmd_t                    init_cmd,          // commands from the power-up sequence
	input  logic [`SDRAM_ROW_W-1:0]       init_a,
	input  logic                          init_done,
	input  logic                          refresh_pending,
	output logic                          refresh_done,      // one cycle after REFRESH is on the bus
	input  logic                          req,               // level, held until ack
	input  logic                          we,                // 1 writes, 0 reads
	input  logic [`SDRAM_HOST_ADDR_W-1:0] addr,
	input  logic [`SDRAM_DATA_W-1:0]      wdata,
	output logic                          ack,               // one cycle pulse per request
	output logic [`SDRAM_DATA_W-1:0]      rdata,             // valid in the ack cycle of a read
	output logic                          ready,             // level, init is over
	output sdram_cmd_t                    sd_cmd,
	output logic [`SDRAM_ROW_W-1:0]       sd_a,
	output logic [`SDRAM_BANK_W-1:0]      sd_ba,
	output logic [`SDRAM_DATA_W-1:0]      sd_dq_out,
	output logic                          sd_dq_oe,          // high only in the WRITE cycle
	input  logic [`SDRAM_DATA_W-1:0]      sd_dq_in
);

	// each state sets up the bus for the following cycle
	typedef enum logic [2:0] {
		st_idle,       // chooses between refresh and a host request
		st_refresh,    // puts AUTO REFRESH on the bus
		st_activate,   // puts ACTIVATE with the row on the bus
		st_rcd_wait,   // NOPs until T_RCD has passed
		st_read,       // puts READ with auto precharge on the bus
		st_cas_wait,   // waits for the data to come back
		st_write,      // puts WRITE with auto precharge and the data on the bus
		st_rp_wait     // trailing NOPs after an access or a refresh
	} state_t;

	state_t                  state;
	logic [3:0]              wait_cnt;   // shared by every wait state
	logic [`SDRAM_ROW_W-1:0] col_addr;   // column word for READ and WRITE

	always_comb begin
		col_addr                      = '0;
		col_addr[`SDRAM_COL_W-1:0]    = host_col(addr);
		col_addr[10]                  = 1'b1;   // a10 asks for auto precharge
	end

	// control state and command bus
	always_ff @(posedge sd_clk) begin
		if (reset) begin
			state        <= st_idle;
			wait_cnt     <= '0;
			sd_cmd       <= cmd_inhibit;
			sd_dq_oe     <= 1'b0;
			ack          <= 1'b0;
			ready        <= 1'b0;
			refresh_done <= 1'b0;
		end else begin
			ready        <= init_done;
			ack          <= 1'b0;                      // pulses only where set below
			sd_dq_oe     <= 1'b0;
			sd_cmd       <= cmd_nop;
			refresh_done <= (sd_cmd == cmd_refresh);   // tells the timer the refresh went out

			if (!init_done) begin
				sd_cmd <= init_cmd;   // power-up sequence owns the bus until it finishes
				state  <= st_idle;
			end else begin
				case (state)
					st_idle: begin
						if (refresh_pending) begin
							state <= st_refresh;   // refresh wins over a waiting request
						end else if (req) begin
							state <= st_activate;
						end
					end
					st_refresh: begin
						sd_cmd   <= cmd_refresh;
						wait_cnt <= 4'(`SDRAM_T_RFC - 1);
						state    <= st_rp_wait;
					end
					st_activate: begin
						sd_cmd   <= cmd_active;
						wait_cnt <= 4'(`SDRAM_T_RCD - 2);   // the access state is the last cycle
						state    <= st_rcd_wait;
					end
					st_rcd_wait: begin
						if (wait_cnt == 4'd0) begin
							state <= we ? st_write : st_read;
						end else begin
							wait_cnt <= wait_cnt - 4'd1;
						end
					end
					st_read: begin
						sd_cmd   <= cmd_read;
						wait_cnt <= 4'(`SDRAM_CAS_LATENCY);   // data is sampled when this hits zero
						state    <= st_cas_wait;
					end
					st_cas_wait: begin
						if (wait_cnt == 4'd0) begin
							ack      <= 1'b1;   // rdata is loaded on the same edge
							wait_cnt <= 4'(`SDRAM_T_RP - 1);
							state    <= st_rp_wait;
						end else begin
							wait_cnt <= wait_cnt - 4'd1;
						end
					end
					st_write: begin
						sd_cmd   <= cmd_write;
						sd_dq_oe <= 1'b1;
						ack      <= 1'b1;   // write is done as far as the host is concerned
						wait_cnt <= 4'(`SDRAM_T_RP - 1);
						state    <= st_rp_wait;
					end
					st_rp_wait: begin
						if (wait_cnt == 4'd0) begin
							state <= st_idle;
						end else begin
							wait_cnt <= wait_cnt - 4'd1;
						end
					end
					default: begin
						state <= st_idle;
					end
				endcase
			end
		end
	end

	// address, bank and data registers follow the same states
	always_ff @(posedge sd_clk) begin
		if (!init_done) begin
			sd_a  <= init_a;
			sd_ba <= '0;   // precharge all and load mode ignore the bank
		end else begin
			case (state)
				st_activate: begin
					sd_a  <= host_row(addr);
					sd_ba <= host_bank(addr);
				end
				st_read: begin
					sd_a  <= col_addr;
					sd_ba <= host_bank(addr);
				end
				st_write: begin
					sd_a      <= col_addr;
					sd_ba     <= host_bank(addr);
					sd_dq_out <= wdata;
				end
				st_cas_wait: begin
					if (wait_cnt == 4'd0) begin
						rdata <= sd_dq_in;   // CAS latency cycles after READ was on the bus
					end
				end
				default: begin
				end
			endcase
		end
	end

	// the host may only see an ack after init has finished
	a_ack_ready: assert property (@(posedge sd_clk) disable iff (reset) ack |-> ready)
		else $error("ack while ready is low");

	a_oe_write: assert property (
		@(posedge sd_clk) disable iff (reset) sd_dq_oe |-> (sd_cmd == cmd_write)
	) else $error("dq driven outside a WRITE cycle");

endmodule

//--- design/sdram_cmd_pkg.sv
// SDRAM bus command encodings as {cs_n, ras_n, cas_n, we_n}
// every bit is active low so all ones deselects the chip

package sdram_cmd_pkg;

	// one command per sd_clk edge, chip select is the top bit
	typedef enum logic [3:0] {
		cmd_load_mode = 4'b0000,   // mode register write, a carries the mode word
		cmd_refresh   = 4'b0001,   // auto refresh, all banks must be idle
		cmd_precharge = 4'b0010,   // a10 high closes every bank
		cmd_active    = 4'b0011,   // opens the row on a in bank ba
		cmd_write     = 4'b0100,   // a10 high adds auto precharge
		cmd_read      = 4'b0101,   // a10 high adds auto precharge
		cmd_nop       = 4'b0111,   // chip selected but nothing to do
		cmd_inhibit   = 4'b1111    // chip deselected
	} sdram_cmd_t;

	// burst terminate (4'b0110) is not used because bursts are always 1 word

endpackage

//--- design/sdram_ctrl_top.sv
// single port SDRAM controller with host strobes on one side and SDRAM pins on the other
// dq is split into out, output enable and in, and a pad or model must combine them
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_ctrl_top
	import sdram_cmd_pkg::*;
(
	input  logic                          sd_clk,
	input  logic                          reset,
	input  logic                          req,         // host request level
	input  logic                          we,
	input  logic [`SDRAM_HOST_ADDR_W-1:0] addr,        // {bank, row, col}
	input  logic [`SDRAM_DATA_W-1:0]      wdata,
	output logic                          ack,
	output logic [`SDRAM_DATA_W-1:0]      rdata,
	output logic                          ready,
	output sdram_cmd_t                    sd_cmd,      // {cs_n, ras_n, cas_n, we_n}
	output logic [`SDRAM_ROW_W-1:0]       sd_a,
	output logic [`SDRAM_BANK_W-1:0]      sd_ba,
	output logic [`SDRAM_DATA_W-1:0]      sd_dq_out,
	output logic                          sd_dq_oe,
	input  logic [`SDRAM_DATA_W-1:0]      sd_dq_in
);

	sdram_cmd_t              init_cmd;          // power-up commands before init_done
	logic [`SDRAM_ROW_W-1:0] init_a;
	logic                    init_done;
	logic                    refresh_pending;   // timer to sequencer
	logic                    refresh_done;      // sequencer back to timer

	sdram_init init_i (
		.sd_clk    (sd_clk),
		.reset     (reset),
		.init_cmd  (init_cmd),
		.init_a    (init_a),
		.init_done (init_done)
	);

	sdram_refresh_timer refresh_timer_i (
		.sd_clk          (sd_clk),
		.reset           (reset),
		.init_done       (init_done),
		.refresh_done    (refresh_done),
		.refresh_pending (refresh_pending)
	);

	sdram_access_seq access_seq_i (
		.sd_clk          (sd_clk),
		.reset           (reset),
		.init_cmd        (init_cmd),
		.init_a          (init_a),
		.init_done       (init_done),
		.refresh_pending (refresh_pending),
		.refresh_done    (refresh_done),
		.req             (req),
		.we              (we),
		.addr            (addr),
		.wdata           (wdata),
		.ack             (ack),
		.rdata           (rdata),
		.ready           (ready),
		.sd_cmd          (sd_cmd),
		.sd_a            (sd_a),
		.sd_ba           (sd_ba),
		.sd_dq_out       (sd_dq_out),
		.sd_dq_oe        (sd_dq_oe),
		.sd_dq_in        (sd_dq_in)
	);

endmodule

//--- design/sdram_host_pkg.sv
// host address field types and the split of a host word address
// the address layout is {bank, row, col} with the bank in the high bits

`include "sdram_settings.svh"

package sdram_host_pkg;

	typedef logic [`SDRAM_BANK_W-1:0] sdram_bank_t;   // bank select on ba
	typedef logic [`SDRAM_ROW_W-1:0]  sdram_row_t;    // row driven on a during ACTIVATE
	typedef logic [`SDRAM_COL_W-1:0]  sdram_col_t;    // column driven on a during READ or WRITE

	function automatic sdram_bank_t host_bank(input logic [`SDRAM_HOST_ADDR_W-1:0] addr);
		return addr[`SDRAM_HOST_ADDR_W-1 -: `SDRAM_BANK_W];   // top bits of the word address
	endfunction

	function automatic sdram_row_t host_row(input logic [`SDRAM_HOST_ADDR_W-1:0] addr);
		return addr[`SDRAM_COL_W +: `SDRAM_ROW_W];   // sits just above the column
	endfunction

	function automatic sdram_col_t host_col(input logic [`SDRAM_HOST_ADDR_W-1:0] addr);
		return addr[`SDRAM_COL_W-1:0];   // lowest bits so neighbouring words share a row
	endfunction

endpackage

//--- design/sdram_init.sv
// power-up sequence for the SDRAM with precharge all and two mode loads, then init_done
// the delay is fixed at 31 steps of 16 cycles and is not scaled to the clock rate
// init_done stays high until the next reset
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_init
	import sdram_cmd_pkg::*;
(
	input  logic                    sd_clk,
	input  logic                    reset,
	output sdram_cmd_t              init_cmd,    // registered command toward the sequencer
	output logic [`SDRAM_ROW_W-1:0] init_a,      // address bits that go with init_cmd
	output logic                    init_done    // level, sequence complete
);

	logic [3:0] t;           // step timer, wraps every 16 cycles
	logic [4:0] countdown;   // counts steps down from 31 to 0

	always_ff @(posedge sd_clk) begin
		init_cmd <= cmd_inhibit;   // chip stays deselected unless a step below says otherwise

		if (reset) begin
			t         <= 4'd0;
			countdown <= 5'h1f;
			init_a    <= '0;
			init_done <= 1'b0;
		end else begin
			if (!init_done) begin
				t <= t + 4'd1;   // stops counting once the sequence is over
			end

			if (t == 4'hf) begin
				countdown <= countdown - 5'd1;   // one step every 16 cycles
			end

			// commands only go out on the first cycle of a step
			if (t == 4'h0) begin
				case (countdown)
					5'd13: begin
						init_cmd   <= cmd_precharge;
						init_a[10] <= 1'b1;   // a10 selects all banks
					end
					5'd2, 5'd1: begin
						init_cmd <= cmd_load_mode;     // loaded twice to be safe after power up
						init_a   <= `SDRAM_MODE_WORD;
					end
					5'd0: begin
						init_done <= 1'b1;   // 497 cycles after reset falls
					end
					default: begin
					end
				endcase
			end
		end
	end

	// the sequencer and refresh timer both rely on init_done being sticky
	a_done_sticky: assert property (@(posedge sd_clk) (init_done && !reset) |=> init_done)
		else $error("init_done fell without reset");

endmodule

//--- design/sdram_refresh_timer.sv
// refresh interval counter that starts once init_done is high
// a pending request is held until the sequencer reports refresh_done, then the count restarts
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_refresh_timer (
	input  logic sd_clk,
	input  logic reset,
	input  logic init_done,        // counting starts after the power-up sequence
	input  logic refresh_done,     // pulse from the sequencer after AUTO REFRESH went out
	output logic refresh_pending   // level, a refresh is owed
);

	localparam int CNT_W = $clog2(`SDRAM_REFRESH_INTERVAL);

	logic [CNT_W-1:0] interval_cnt;   // cycles since the last refresh was serviced

	always_ff @(posedge sd_clk) begin
		if (reset || !init_done) begin
			interval_cnt    <= '0;     // no refresh is owed before the chip is set up
			refresh_pending <= 1'b0;
		end else if (refresh_done) begin
			interval_cnt    <= '0;     // the interval counts from the end of the refresh
			refresh_pending <= 1'b0;
		end else if (!refresh_pending) begin
			if (interval_cnt == CNT_W'(`SDRAM_REFRESH_INTERVAL - 1)) begin
				refresh_pending <= 1'b1;   // count holds here until serviced
			end else begin
				interval_cnt <= interval_cnt + 1'b1;
			end
		end
	end

	// the sequencer must only service a refresh it was asked for
	a_done_when_pending: assert property (
		@(posedge sd_clk) disable iff (reset) refresh_done |-> refresh_pending
	) else $error("refresh_done without a pending refresh");

endmodule

//--- design/sdram_settings.svh
// widths, timing counts and mode word for a 16-bit SDR SDRAM with 4 banks
// all timing counts are in sd_clk cycles and the sequencer needs T_RCD, T_RP and T_RFC of 2 or more

`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

`define SDRAM_ROW_W 13          // row address bits, also the width of the a bus
`define SDRAM_COL_W 9           // column address bits
`define SDRAM_BANK_W 2          // four banks
`define SDRAM_DATA_W 16         // dq width

// host word address is {bank, row, col} with bank on top
`define SDRAM_HOST_ADDR_W 24

`define SDRAM_CAS_LATENCY 2     // read data shows up this many cycles after READ
`define SDRAM_T_RCD 2           // ACTIVATE to READ or WRITE
`define SDRAM_T_RP 2            // idle cycles after an auto precharged access
`define SDRAM_T_RFC 4           // NOP cycles after AUTO REFRESH

// 7.8 us at 25 MHz gives 195 cycles between refresh requests
`define SDRAM_REFRESH_INTERVAL 195

// mode register fields from a0 upward
// burst length 1 (a2:a0 = 000), sequential (a3 = 0), cas latency 2 (a6:a4 = 010)
// standard operation (a8:a7 = 00), single location write (a9 = 1)
`define SDRAM_MODE_WORD 13'h220

`endif

//--- dv/sdram_bus_model.sv
// behavioral SDR SDRAM for simulation with one word per access and no power-down
// read latency comes from the loaded mode register and unwritten words read back as x
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_bus_model
	import sdram_cmd_pkg::*;
	import sdram_host_pkg::*;
(
	input  logic                     sd_clk,
	input  sdram_cmd_t               sd_cmd,
	input  logic [`SDRAM_ROW_W-1:0]  sd_a,
	input  logic [`SDRAM_BANK_W-1:0] sd_ba,
	input  logic [`SDRAM_DATA_W-1:0] sd_dq_out,
	input  logic                     sd_dq_oe,
	output logic [`SDRAM_DATA_W-1:0] sd_dq_in,
	output logic                     protocol_error,   // one cycle pulse for each bad cycle
	output int                       refresh_count     // AUTO REFRESH commands seen so far
);

	localparam int BANKS = 1 << `SDRAM_BANK_W;

	logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_HOST_ADDR_W-1:0]];   // sparse, keyed {ba, row, col}
	logic                          bank_open [BANKS];
	sdram_row_t                    open_row [BANKS];
	int                            act_cycle [BANKS];    // cycle of the last ACTIVATE per bank
	int                            free_cycle [BANKS];   // first cycle the bank may be used again
	int                            cycle = 0;
	int                            rfc_until = 0;        // no command before this cycle
	logic                          mode_set = 1'b0;
	logic [`SDRAM_ROW_W-1:0]       mode;
	logic                          bad;
	logic                          banks_busy;
	logic                          rd_busy = 1'b0;       // read data is on its way
	logic [2:0]                    rd_left;              // cycles until the data word is driven
	logic [`SDRAM_DATA_W-1:0]      rd_word;
	sdram_col_t                    col;
	logic [`SDRAM_HOST_ADDR_W-1:0] key;

	initial begin
		protocol_error = 1'b0;
		refresh_count  = 0;
		for (int b = 0; b < BANKS; b++) begin
			bank_open[b]  = 1'b0;
			free_cycle[b] = 0;
		end
	end

	assign sd_dq_in = (rd_busy && rd_left == 3'd0) ? rd_word : 'x;   // only valid in the data slot

	task automatic report_violation(input string msg);
		$display("model error at cycle %0d: %s", cycle, msg);
		bad = 1'b1;
	endtask

	always @(posedge sd_clk) begin
		bad = 1'b0;
		col = sd_a[`SDRAM_COL_W-1:0];
		key = {sd_ba, open_row[sd_ba], col};
		if (rd_busy) begin
			if (rd_left == 3'd0) rd_busy <= 1'b0;   // data slot is over
			else rd_left <= rd_left - 3'd1;
		end
		if (sd_cmd != cmd_inhibit && sd_cmd != cmd_nop && cycle < rfc_until)
			report_violation("command issued inside T_RFC after AUTO REFRESH");
		if (sd_dq_oe === 1'b1 && rd_busy && rd_left == 3'd0)
			report_violation("dq driven while read data is returned");
		case (sd_cmd)
			cmd_load_mode: begin
				mode     = sd_a;
				mode_set = 1'b1;
			end
			cmd_precharge: begin
				for (int b = 0; b < BANKS; b++) begin
					if (sd_a[10] || sd_ba == b) begin
						bank_open[b]  = 1'b0;
						free_cycle[b] = cycle + `SDRAM_T_RP;
					end
				end
			end
			cmd_refresh: begin
				banks_busy = 1'b0;
				for (int b = 0; b < BANKS; b++) begin
					if (bank_open[b] || cycle < free_cycle[b]) banks_busy = 1'b1;
				end
				if (banks_busy) report_violation("AUTO REFRESH while a bank is not precharged");
				refresh_count++;
				rfc_until = cycle + `SDRAM_T_RFC;
			end
			cmd_active: begin
				if (bank_open[sd_ba]) report_violation("ACTIVATE to a bank that is still open");
				else if (cycle < free_cycle[sd_ba])
					report_violation("ACTIVATE before the precharge time has passed");
				bank_open[sd_ba] = 1'b1;
				open_row[sd_ba]  = sd_a;
				act_cycle[sd_ba] = cycle;
			end
			cmd_read, cmd_write: begin
				if (!bank_open[sd_ba]) report_violation("READ or WRITE with no active row");
				else if (cycle - act_cycle[sd_ba] < `SDRAM_T_RCD)
					report_violation("READ or WRITE issued before T_RCD");
				if (sd_cmd == cmd_write) begin
					if (sd_dq_oe !== 1'b1) report_violation("WRITE without dq driven");
					mem[key] = sd_dq_out;
				end else if (!mode_set) begin
					report_violation("READ before the mode register was loaded");
				end else begin
					rd_word <= mem.exists(key) ? mem[key] : 'x;
					rd_busy <= 1'b1;
					rd_left <= mode[6:4] - 3'd1;   // cas latency field of the mode word
				end
				if (sd_a[10]) begin
					bank_open[sd_ba]  = 1'b0;   // auto precharge closes the row
					free_cycle[sd_ba] = cycle + 1 + `SDRAM_T_RP;
				end
			end
			default: begin
			end
		endcase
		protocol_error <= bad;
		cycle = cycle + 1;
	end

endmodule

//--- dv/sdram_ctrl_tb.sv
// testbench for the SDRAM controller against a behavioral SDRAM on the split dq bus
// covers init order, a table of writes and reads, an idle refresh window and random traffic
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_ctrl_tb
	import sdram_cmd_pkg::*;
();

	localparam int READY_TIMEOUT   = 1000;   // cycles from reset release
	localparam int ACK_TIMEOUT     = 400;    // covers a refresh ahead of the access
	localparam int IDLE_WINDOW     = 2000;
	localparam int RANDOM_ACCESSES = 60;

	typedef struct packed {
		logic                          we;
		logic [`SDRAM_HOST_ADDR_W-1:0] addr;
		logic [`SDRAM_DATA_W-1:0]      wdata;
		logic [`SDRAM_DATA_W-1:0]      exp;   // checked for reads only
	} entry_t;

	logic                          sd_clk;
	logic                          reset;
	logic                          req;
	logic                          we;
	logic [`SDRAM_HOST_ADDR_W-1:0] addr;
	logic [`SDRAM_DATA_W-1:0]      wdata;
	logic                          ack;
	logic [`SDRAM_DATA_W-1:0]      rdata;
	logic                          ready;
	sdram_cmd_t                    sd_cmd;
	logic [`SDRAM_ROW_W-1:0]       sd_a;
	logic [`SDRAM_BANK_W-1:0]      sd_ba;
	logic [`SDRAM_DATA_W-1:0]      sd_dq_out;
	logic                          sd_dq_oe;
	logic [`SDRAM_DATA_W-1:0]      sd_dq_in;
	logic                          protocol_error;
	int                            refresh_count;

	int                            seed = 28142;
	int                            check_errs = 0;
	int                            model_errs = 0;
	int                            timeouts = 0;
	int                            req_count = 0;
	int                            ack_count = 0;
	entry_t                        stim_table[$];
	sdram_cmd_t                    init_cmds[$];      // bus commands seen before ready
	logic [`SDRAM_ROW_W-1:0]       init_addrs[$];
	logic [`SDRAM_HOST_ADDR_W-1:0] pool [0:7];        // addresses used by the random traffic
	logic [`SDRAM_DATA_W-1:0]      shadow [0:7];      // last value written to each pool address

	initial sd_clk = 1'b0;
	always #20 sd_clk = ~sd_clk;   // 40 ns period

	sdram_ctrl_top dut_i (
		.sd_clk(sd_clk), .reset(reset), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.ack(ack), .rdata(rdata), .ready(ready), .sd_cmd(sd_cmd), .sd_a(sd_a), .sd_ba(sd_ba),
		.sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe), .sd_dq_in(sd_dq_in)
	);

	sdram_bus_model model_i (
		.sd_clk(sd_clk), .sd_cmd(sd_cmd), .sd_a(sd_a), .sd_ba(sd_ba), .sd_dq_out(sd_dq_out),
		.sd_dq_oe(sd_dq_oe), .sd_dq_in(sd_dq_in), .protocol_error(protocol_error),
		.refresh_count(refresh_count)
	);

	// outputs change on the rising edge so the falling edge sees them settled
	always @(negedge sd_clk) begin
		if (protocol_error) model_errs++;
		if (ack) ack_count++;
		if (!reset && !ready && sd_cmd !== cmd_inhibit) begin
			init_cmds.push_back(sd_cmd);
			init_addrs.push_back(sd_a);
		end
	end

	task automatic compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			check_errs++;
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic add_entry(input logic w, input logic [23:0] a, input logic [15:0] d,
		input logic [15:0] e);
		stim_table.push_back({w, a, d, e});
	endtask

	task automatic start_request(input logic w, input logic [23:0] a, input logic [15:0] d);
		req   = 1'b1;   // called just after a falling edge
		we    = w;
		addr  = a;
		wdata = d;
		req_count++;
	endtask

	task automatic finish_request(input logic w, input logic [15:0] exp);
		int cycles;
		cycles = 0;
		@(negedge sd_clk);
		while (!ack && cycles < ACK_TIMEOUT) begin
			@(negedge sd_clk);
			cycles++;
		end
		if (!ack) begin
			timeouts++;
			$display("timeout: no ack within %0d cycles for address 0x%0h", ACK_TIMEOUT, addr);
		end else if (!w) begin
			compare_value("rdata", rdata, exp);
		end
		req = 1'b0;
		@(negedge sd_clk);
		compare_value("ack", ack, 1'b0);   // ack is a single cycle pulse
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready && cycles < READY_TIMEOUT) begin
			@(negedge sd_clk);
			cycles++;
			if (ack && !ready) begin
				check_errs++;
				$display("ack arrived while ready was still low");
			end
		end
		if (!ready) begin
			timeouts++;
			$display("timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
		end
	endtask

	task automatic check_init_sequence();
		compare_value("init command count", init_cmds.size(), 3);
		if (init_cmds.size() == 3) begin
			compare_value("init sd_cmd 0", init_cmds[0], cmd_precharge);
			compare_value("init sd_a[10] 0", init_addrs[0][10], 1'b1);   // precharge all
			for (int i = 1; i < 3; i++) begin
				compare_value("init sd_cmd", init_cmds[i], cmd_load_mode);
				compare_value("init sd_a", init_addrs[i], `SDRAM_MODE_WORD);
			end
		end
	endtask

	task automatic idle_gap(input int max_gap);
		int n;
		n = $unsigned($random(seed)) % max_gap;
		repeat (n + 1) @(negedge sd_clk);
	endtask

	initial begin
		int refs_before;
		int refs_min;
		int idx;
		logic w;
		logic [15:0] d;
		reset = 1'b1;
		req   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		// writes spread over banks, rows and columns, one overwrite, then reads of every address
		add_entry(1, {2'd1, 13'd100, 9'd0}, 16'hbeef, 16'h0);
		add_entry(1, {2'd2, 13'h1fff, 9'h1ff}, 16'hc0de, 16'h0);
		add_entry(1, {2'd3, 13'd0, 9'd17}, 16'h0f0f, 16'h0);
		add_entry(1, {2'd0, 13'd5, 9'd4}, 16'h5a5a, 16'h0);
		add_entry(1, {2'd1, 13'd101, 9'd0}, 16'h1111, 16'h0);
		add_entry(1, {2'd3, 13'h0aaa, 9'h155}, 16'h8001, 16'h0);
		add_entry(1, {2'd2, 13'd7, 9'd8}, 16'h7e7e, 16'h0);
		add_entry(1, {2'd2, 13'h1fff, 9'h1ff}, 16'h3c3c, 16'h0);   // overwrites the second entry
		add_entry(0, {2'd0, 13'd5, 9'd3}, 16'h0, 16'h1234);        // written during init
		add_entry(0, {2'd1, 13'd100, 9'd0}, 16'h0, 16'hbeef);
		add_entry(0, {2'd2, 13'h1fff, 9'h1ff}, 16'h0, 16'h3c3c);
		add_entry(0, {2'd3, 13'd0, 9'd17}, 16'h0, 16'h0f0f);
		add_entry(0, {2'd0, 13'd5, 9'd4}, 16'h0, 16'h5a5a);
		add_entry(0, {2'd1, 13'd101, 9'd0}, 16'h0, 16'h1111);
		add_entry(0, {2'd3, 13'h0aaa, 9'h155}, 16'h0, 16'h8001);
		add_entry(0, {2'd2, 13'd7, 9'd8}, 16'h0, 16'h7e7e);
		repeat (16) @(negedge sd_clk);
		// bus deselected, no ack, not ready and dq released while reset is held
		compare_value("sd_cmd", sd_cmd, cmd_inhibit);
		compare_value("ack", ack, 1'b0);
		compare_value("ready", ready, 1'b0);
		compare_value("sd_dq_oe", sd_dq_oe, 1'b0);
		reset = 1'b0;
		@(negedge sd_clk);
		start_request(1'b1, {2'd0, 13'd5, 9'd3}, 16'h1234);   // held through init
		wait_ready();
		check_init_sequence();
		finish_request(1'b1, 16'h0);
		for (int i = 0; i < stim_table.size(); i++) begin
			idle_gap(4);
			start_request(stim_table[i].we, stim_table[i].addr, stim_table[i].wdata);
			finish_request(stim_table[i].we, stim_table[i].exp);
		end
		refs_before = refresh_count;
		repeat (IDLE_WINDOW) @(negedge sd_clk);
		refs_min = IDLE_WINDOW / (`SDRAM_REFRESH_INTERVAL + `SDRAM_T_RFC);
		if (refresh_count - refs_before < refs_min) begin
			check_errs++;
			$display("FAIL refresh_count got 0x%0h expected at least 0x%0h",
				refresh_count - refs_before, refs_min);
		end
		for (int i = 0; i < 8; i++) begin
			pool[i]   = stim_table[8 + i].addr;
			shadow[i] = stim_table[8 + i].exp;
		end
		// long random gaps let refreshes land between and in front of requests
		for (int n = 0; n < RANDOM_ACCESSES; n++) begin
			idx = $unsigned($random(seed)) % 8;
			w   = $unsigned($random(seed)) % 2;
			d   = $random(seed);
			idle_gap(48);
			start_request(w, pool[idx], d);
			finish_request(w, shadow[idx]);
			if (w) shadow[idx] = d;
		end
		compare_value("ack count", ack_count, req_count);
		$display("errors: %0d check, %0d model, %0d timeout", check_errs, model_errs, timeouts);
		if (check_errs == 0 && model_errs == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- sdram_ctrl.f
+incdir+design
design/sdram_cmd_pkg.sv
design/sdram_host_pkg.sv
design/sdram_init.sv
design/sdram_refresh_timer.sv
design/sdram_access_seq.sv
design/sdram_ctrl_top.sv
dv/sdram_bus_model.sv
dv/sdram_ctrl_tb.sv
